//--- gem_cluster_pkg.sv
package gem_cluster_pkg;

  // ----------------------------
  // cluster word format
  // ----------------------------
  localparam int n_clusters   = 4;   // clusters per bunch crossing
  localparam int cluster_bits = 14;  // one cluster word on the link

  typedef logic [10:0] cluster_adr_t;  // vfat number in 10:6, strip pair in 5:0

  typedef struct packed {
    logic [2:0]   cnt;  // cluster size minus one
    cluster_adr_t adr;
  } cluster_t;

  typedef cluster_t [n_clusters-1:0] cluster_array_t;  // 56 bit crossing word

  // ----------------------------
  // chamber geometry
  // ----------------------------
  localparam int n_vfat_per_roll = 3;                         // vfats across one eta partition
  localparam int n_roll          = 8;                         // eta partitions
  localparam int n_vfat          = n_vfat_per_roll * n_roll;  // legal vfat numbers 0-23
  localparam int n_feb           = 24;                        // one vfat per front-end board

  typedef logic [4:0]       vfat_t;
  typedef logic [4:0]       feb_t;
  typedef logic [2:0]       roll_t;
  typedef logic [7:0]       pad_t;       // pad within a roll, no vfat boundary
  typedef logic [n_feb-1:0] feb_list_t;  // one bit per board

  // decoded values for vfat numbers 24-31
  localparam feb_t feb_invalid = 5'd24;
  localparam pad_t pad_invalid = 8'd192;

endpackage

//--- gem_inj_pkg.sv
package gem_inj_pkg;

  // ----------------------------
  // injector ram geometry
  // ----------------------------
  localparam int inj_tbins     = 1024;  // time bins per cluster ram
  localparam int tbin_bits     = 10;
  localparam int tbin_cnt_bits = 12;    // count may run past the ram and wrap
  localparam int inj_word_bits = 16;

  // apb word address: ram select on top, time bin below
  localparam int apb_addr_bits = 12;
  localparam int ram_sel_bits  = apb_addr_bits - tbin_bits;

  typedef logic [tbin_bits-1:0]     tbin_t;
  typedef logic [tbin_cnt_bits-1:0] tbin_cnt_t;
  typedef logic [inj_word_bits-1:0] inj_word_t;
  typedef logic [apb_addr_bits-1:0] apb_addr_t;
  typedef logic [ram_sel_bits-1:0]  ram_sel_t;

  typedef enum logic {inj_pass, inj_playing} inj_state_t;

endpackage

//--- gem_decoded_if.sv
`timescale 1ns/10ps

interface gem_decoded_if import gem_cluster_pkg::*; ();

  cluster_array_t        clusters;  // cluster words as received
  logic [n_clusters-1:0] vpf;       // valid pattern flag per cluster
  feb_t [n_clusters-1:0] feb;       // front-end board of each cluster
  roll_t [n_clusters-1:0] roll;     // eta partition
  pad_t [n_clusters-1:0] pad;       // pad in the roll
  logic                  injected;  // crossing came from the injector rams

  modport source (output clusters, vpf, feb, roll, pad, injected);

  modport sink (input vpf, feb);  // occupancy only needs board and valid

  modport monitor (input clusters, vpf, feb, roll, pad, injected);

endinterface

//--- gem_inj_seq.sv
`timescale 1ns/10ps

module gem_inj_seq import gem_inj_pkg::*; (
  input  logic      clock,
  input  logic      sm_reset,
  input  logic      inj_go,         // start playback
  input  tbin_cnt_t inj_last_tbin,  // last time bin played
  output tbin_t     tbin_adr,       // ram read address
  output logic      playing,        // busy flag, also blocks apb writes
  output logic      use_inj         // playing delayed to line up with ram data
);

  inj_state_t state;
  tbin_cnt_t  tbin_cnt;
  logic       cnt_done;

  assign cnt_done = (tbin_cnt == inj_last_tbin);

  // ----------------------------
  // injector fsm
  // ----------------------------
  always_ff @(posedge clock) begin
    if (sm_reset) begin
      state <= inj_pass;
    end else begin
      case (state)
        inj_pass:    if (inj_go)   state <= inj_playing;
        inj_playing: if (cnt_done) state <= inj_pass;
        default:                   state <= inj_pass;
      endcase
    end
  end

  // time bin counter, held at zero between playbacks
  always_ff @(posedge clock) begin
    if (sm_reset || state == inj_pass) tbin_cnt <= '0;
    else                               tbin_cnt <= tbin_cnt + 1'b1;
  end

  always_ff @(posedge clock) begin
    if (sm_reset) use_inj <= 1'b0;
    else          use_inj <= playing;  // ram output is one cycle behind the address
  end

  assign playing  = (state == inj_playing);
  assign tbin_adr = tbin_cnt[tbin_bits-1:0];  // past 1023 wraps the ram
endmodule

//--- gem_inj_ram.sv
`timescale 1ns/10ps

module gem_inj_ram import gem_cluster_pkg::*, gem_inj_pkg::*; (
  input  logic           clock,
  input  logic           sm_reset,
  input  apb_addr_t      paddr,
  input  logic           psel,
  input  logic           penable,
  input  logic           pwrite,
  input  inj_word_t      pwdata,
  output inj_word_t      prdata,
  output logic           pready,
  output logic           pslverr,
  input  logic           busy,          // sequencer is playing out
  input  tbin_t          tbin_adr,      // play side read address
  output cluster_array_t inj_clusters   // one cycle after tbin_adr
);

  ram_sel_t  ram_sel;
  tbin_t     ram_adr;
  logic      access;
  logic      wr_en;
  logic      rd_ack;                    // second access cycle of a read
  inj_word_t rd_word   [n_clusters];
  inj_word_t play_word [n_clusters];

  // ----------------------------
  // apb side
  // ----------------------------
  assign ram_sel = paddr[apb_addr_bits-1:tbin_bits];   // which cluster ram
  assign ram_adr = paddr[tbin_bits-1:0];               // time bin
  assign access  = psel && penable;
  assign wr_en   = access && pwrite && !busy;          // rejected while playing

  always_ff @(posedge clock) begin
    if (sm_reset) rd_ack <= 1'b0;
    else          rd_ack <= access && !pwrite && !rd_ack;  // one wait state on reads
  end

  assign pready  = access && (pwrite || rd_ack);  // writes finish in the first access cycle
  assign pslverr = access && pwrite && busy;
  assign prdata  = rd_word[ram_sel];              // paddr holds through the transfer

  // ----------------------------
  // four cluster rams
  // ----------------------------
  for (genvar i = 0; i < n_clusters; i++) begin : g_ram
    inj_word_t mem [inj_tbins];

    initial for (int t = 0; t < inj_tbins; t++) mem[t] = '1;  // all ones decodes invalid

    always_ff @(posedge clock) begin
      if (wr_en && ram_sel == i) mem[ram_adr] <= pwdata;
      rd_word[i]   <= mem[ram_adr];    // read first on the apb port
      play_word[i] <= mem[tbin_adr];
    end

    assign inj_clusters[i] = play_word[i][cluster_bits-1:0];  // top 2 bits unused
  end

endmodule

//--- gem_cluster_select.sv
`timescale 1ns/10ps

module gem_cluster_select import gem_cluster_pkg::*; (
  input  logic           clock,
  input  logic           sm_reset,
  input  cluster_array_t link_clusters,  // live link word
  input  cluster_array_t inj_clusters,   // injector ram word
  input  logic           use_inj,
  output cluster_array_t sel_clusters,
  output logic           sel_injected    // source flag travels with the data
);

  // ----------------------------
  // stage 1 source mux
  // ----------------------------
  always_ff @(posedge clock) begin
    if (sm_reset) begin
      sel_clusters <= '1;    // all ones decode as invalid clusters
      sel_injected <= 1'b0;
    end else begin
      sel_clusters <= use_inj ? inj_clusters : link_clusters;
      sel_injected <= use_inj;
    end
  end

endmodule

//--- gem_cluster_decode.sv
`timescale 1ns/10ps

module gem_cluster_decode import gem_cluster_pkg::*; (
  input  logic           clock,
  input  logic           sm_reset,
  input  cluster_array_t sel_clusters,
  input  logic           sel_injected,
  gem_decoded_if.source  dec
);

  logic [n_clusters-1:0]  vpf_c;
  feb_t [n_clusters-1:0]  feb_c;
  roll_t [n_clusters-1:0] roll_c;
  pad_t [n_clusters-1:0]  pad_c;

  // ----------------------------
  // vfat to board, roll and pad
  // ----------------------------
  always_comb begin : map_c
    vfat_t      v;
    roll_t      roll;
    logic [1:0] r;                                   // vfat position across the roll
    for (int i = 0; i < n_clusters; i++) begin
      v        = sel_clusters[i].adr[10:6];          // natural vfat id
      r        = 2'(v % n_vfat_per_roll);
      roll     = roll_t'(v / n_vfat_per_roll);
      vpf_c[i] = (sel_clusters[i].adr[10:9] != 2'b11);
      if (v < n_vfat) begin
        roll_c[i] = roll;
        feb_c[i]  = feb_t'(roll + n_roll * r);       // boards 0-7 left, 8-15 mid, 16-23 right
        pad_c[i]  = {r, sel_clusters[i].adr[5:0]};
      end else begin
        roll_c[i] = '0;
        feb_c[i]  = feb_invalid;
        pad_c[i]  = pad_invalid;
      end
    end
  end

  // stage 2 register
  always_ff @(posedge clock) begin
    if (sm_reset) begin
      dec.vpf      <= '0;
      dec.injected <= 1'b0;
    end else begin
      dec.vpf      <= vpf_c;
      dec.injected <= sel_injected;
    end
    dec.clusters <= sel_clusters;
    dec.feb      <= feb_c;
    dec.roll     <= roll_c;
    dec.pad      <= pad_c;
  end

endmodule

//--- gem_feb_occupancy.sv
`timescale 1ns/10ps

module gem_feb_occupancy import gem_cluster_pkg::*; (
  input  logic        clock,
  input  logic        sm_reset,
  gem_decoded_if.sink dec,
  output feb_list_t   active_feb_list  // usable for a gem-only self trigger
);

  feb_list_t list_c;

  always_comb begin
    list_c = '0;
    for (int i = 0; i < n_clusters; i++) begin
      if (dec.vpf[i] && dec.feb[i] < n_feb) list_c[dec.feb[i]] = 1'b1;  // or over clusters
    end
  end

  // stage 3 register
  always_ff @(posedge clock) begin
    if (sm_reset) active_feb_list <= '0;
    else          active_feb_list <= list_c;
  end

endmodule

//--- gem_cluster_top.sv
`timescale 1ns/10ps

module gem_cluster_top import gem_cluster_pkg::*, gem_inj_pkg::*; (
  input  logic                   clock,
  input  logic                   sm_reset,
  input  cluster_array_t         link_clusters,   // four clusters per crossing
  // apb slave to the injector rams
  input  apb_addr_t              paddr,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  inj_word_t              pwdata,
  output inj_word_t              prdata,
  output logic                   pready,
  output logic                   pslverr,
  // injector control
  input  logic                   inj_go,
  input  tbin_cnt_t              inj_last_tbin,
  // decoded clusters
  output cluster_array_t         clusters,
  output logic [n_clusters-1:0]  cluster_vpf,
  output feb_t [n_clusters-1:0]  cluster_feb,
  output roll_t [n_clusters-1:0] cluster_roll,
  output pad_t [n_clusters-1:0]  cluster_pad,
  output logic                   cluster_injected,
  output feb_list_t              active_feb_list,
  output logic                   inj_busy
);

  tbin_t          tbin_adr;
  logic           use_inj;
  cluster_array_t inj_clusters;
  cluster_array_t sel_clusters;
  logic           sel_injected;

  gem_decoded_if dec_bus ();

  // ----------------------------
  // injector
  // ----------------------------
  gem_inj_seq u_seq (
    .clock, .sm_reset, .inj_go, .inj_last_tbin,
    .tbin_adr, .playing (inj_busy), .use_inj
  );

  gem_inj_ram u_ram (
    .clock, .sm_reset, .paddr, .psel, .penable, .pwrite, .pwdata,
    .prdata, .pready, .pslverr,
    .busy (inj_busy), .tbin_adr, .inj_clusters
  );

  // ----------------------------
  // cluster pipeline
  // ----------------------------
  gem_cluster_select u_select (
    .clock, .sm_reset, .link_clusters, .inj_clusters, .use_inj,
    .sel_clusters, .sel_injected
  );

  gem_cluster_decode u_decode (
    .clock, .sm_reset, .sel_clusters, .sel_injected, .dec (dec_bus)
  );

  gem_feb_occupancy u_occupancy (
    .clock, .sm_reset, .dec (dec_bus), .active_feb_list  // one cycle after decode
  );

  assign clusters         = dec_bus.clusters;
  assign cluster_vpf      = dec_bus.vpf;
  assign cluster_feb      = dec_bus.feb;
  assign cluster_roll     = dec_bus.roll;
  assign cluster_pad      = dec_bus.pad;
  assign cluster_injected = dec_bus.injected;

endmodule

//--- gem_cluster_checker.sv
`timescale 1ns/10ps

module gem_cluster_checker (
  input logic clock,
  input logic sm_reset,
  input logic psel,
  input logic penable,
  input logic pready,
  input logic pslverr,
  input logic inj_go,
  input logic inj_busy
);

  // ------------------------------
  // apb handshake
  // ------------------------------
  ready_in_access: assert property (@(posedge clock) disable iff (sm_reset)
    pready |-> (psel && penable))
    else $error("pready high outside an APB access phase");

  error_with_ready: assert property (@(posedge clock) disable iff (sm_reset)
    pslverr |-> pready)
    else $error("pslverr high without pready");

  // playback only starts from a go pulse
  busy_after_go: assert property (@(posedge clock) disable iff (sm_reset)
    $rose(inj_busy) |-> $past(inj_go))
    else $error("inj_busy rose without inj_go in the cycle before");

endmodule

bind gem_cluster_top gem_cluster_checker u_checker (
  .clock, .sm_reset, .psel, .penable, .pready, .pslverr, .inj_go, .inj_busy
);

//--- tb_gem_cluster_top.sv
`timescale 1ns/10ps

module tb_gem_cluster_top import gem_cluster_pkg::*, gem_inj_pkg::*; ();

  localparam int n_sweep        = 8;                        // 32 vfat numbers in rows of four
  localparam int n_random       = 60;
  localparam int n_rows         = n_sweep + 1 + n_random;
  localparam int play_len       = (5 + 1) + (20 + 1);       // both playbacks
  localparam int timeout_cycles = 2 * n_rows + play_len + 200;

  logic clock, sm_reset, psel, penable, pwrite, pready, pslverr;
  logic inj_go, inj_busy, cluster_injected;
  apb_addr_t              paddr;
  inj_word_t              pwdata, prdata;
  tbin_cnt_t              inj_last_tbin;
  cluster_array_t         link_clusters, clusters;
  logic [n_clusters-1:0]  cluster_vpf;
  feb_t [n_clusters-1:0]  cluster_feb;
  roll_t [n_clusters-1:0] cluster_roll;
  pad_t [n_clusters-1:0]  cluster_pad;
  feb_list_t              active_feb_list;

  // stimulus table with expected decode per row
  string                  name_q [$];
  cluster_array_t         stim_q [$];
  logic [n_clusters-1:0]  vpf_q  [$];
  feb_t [n_clusters-1:0]  feb_q  [$];
  roll_t [n_clusters-1:0] roll_q [$];
  pad_t [n_clusters-1:0]  pad_q  [$];
  feb_list_t              list_q [$];
  int                     row_errs [n_rows];
  inj_word_t              inj_mem [n_clusters][6];  // words 0-5 of each injector ram

  int seed         = 90;
  int error_count  = 0;
  int tests_run    = 0;
  int tests_failed = 0;
  int cycle_count  = 0;

  gem_cluster_top dut (.*);

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;  // 4 ns period
  end

  always @(posedge clock) begin
    cycle_count++;
    if (cycle_count > timeout_cycles) begin
      $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
      $display("Regression failed");
      $finish;
    end
  end

  // ------------------------------
  // reference decode and checks
  // ------------------------------
  function automatic void map_cluster(input cluster_t c, output logic vpf, output feb_t feb,
                                      output roll_t roll, output pad_t pad);
    int v;
    int pos;
    v    = int'(c.adr[10:6]);
    pos  = v % n_vfat_per_roll;         // 0 left, 1 middle, 2 right
    vpf  = !(c.adr[10] && c.adr[9]);
    feb  = feb_invalid;
    roll = '0;
    pad  = pad_invalid;
    if (v < n_vfat) begin
      roll = roll_t'(v / n_vfat_per_roll);
      feb  = feb_t'(v / n_vfat_per_roll + 8 * pos);
      pad  = pad_t'(64 * pos + int'(c.adr[5:0]));  // position above the strip pair
    end
  endfunction

  task automatic expect_row(input cluster_array_t data, output logic [n_clusters-1:0] vpf,
                            output feb_t [n_clusters-1:0] feb, output roll_t [n_clusters-1:0] roll,
                            output pad_t [n_clusters-1:0] pad, output feb_list_t list);
    list = '0;
    for (int j = 0; j < n_clusters; j++) begin
      map_cluster(data[j], vpf[j], feb[j], roll[j], pad[j]);
      if (vpf[j] && feb[j] != feb_invalid) list[feb[j]] = 1'b1;
    end
  endtask

  task automatic add_row(input string name, input cluster_array_t data);
    logic [n_clusters-1:0]  vpf;
    feb_t [n_clusters-1:0]  feb;
    roll_t [n_clusters-1:0] roll;
    pad_t [n_clusters-1:0]  pad;
    feb_list_t              list;
    expect_row(data, vpf, feb, roll, pad, list);
    name_q.push_back(name);
    stim_q.push_back(data);
    vpf_q.push_back(vpf);
    feb_q.push_back(feb);
    roll_q.push_back(roll);
    pad_q.push_back(pad);
    list_q.push_back(list);
  endtask

  function automatic void check_value(input string test, input string what,
                                      input logic [63:0] exp, input logic [63:0] act);
    assert (exp === act) else begin
      $display("CHECK FAILED %s %s: expected %h actual %h", test, what, exp, act);
      error_count++;
    end
  endfunction

  // sampled at the falling edge between updates
  task automatic check_outputs(input string test, input cluster_array_t data,
                               input logic [n_clusters-1:0] vpf, input feb_t [n_clusters-1:0] feb,
                               input roll_t [n_clusters-1:0] roll,
                               input pad_t [n_clusters-1:0] pad, input logic inj);
    check_value(test, "clusters", 64'(data), 64'(clusters));
    check_value(test, "vpf", 64'(vpf), 64'(cluster_vpf));
    check_value(test, "feb", 64'(feb), 64'(cluster_feb));
    check_value(test, "roll", 64'(roll), 64'(cluster_roll));
    check_value(test, "pad", 64'(pad), 64'(cluster_pad));
    check_value(test, "injected", 64'(inj), 64'(cluster_injected));
  endtask

  task automatic test_done(input string name, input int errs);
    tests_run++;
    if (errs != 0) tests_failed++;
    $display("%-16s %s", name, (errs == 0) ? "ok" : "FAILED");
  endtask

  // ------------------------------
  // apb and injector control
  // ------------------------------
  task automatic apb_write(input apb_addr_t addr, input inj_word_t data, output logic err);
    @(posedge clock);
    paddr  <= addr;                     // setup phase
    pwdata <= data;
    pwrite <= 1'b1;
    psel   <= 1'b1;
    @(posedge clock);
    penable <= 1'b1;                    // access phase
    @(negedge clock);
    while (!pready) @(negedge clock);
    err = pslverr;
    @(posedge clock);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apb_read(input apb_addr_t addr, output inj_word_t data, output int waits);
    @(posedge clock);
    paddr  <= addr;
    pwrite <= 1'b0;
    psel   <= 1'b1;
    @(posedge clock);
    penable <= 1'b1;
    waits = 0;
    @(negedge clock);
    while (!pready) begin
      waits++;                          // access cycles with pready low
      @(negedge clock);
    end
    data = prdata;
    @(posedge clock);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic start_playback(input tbin_cnt_t last);
    @(posedge clock);
    inj_last_tbin <= last;
    inj_go        <= 1'b1;
    @(posedge clock);
    inj_go <= 1'b0;                     // single cycle start pulse
  endtask

  // ------------------------------
  // test sequence
  // ------------------------------
  initial begin
    cluster_array_t         stim;
    logic [63:0]            rnd;
    logic [n_clusters-1:0]  exp_vpf;
    feb_t [n_clusters-1:0]  exp_feb;
    roll_t [n_clusters-1:0] exp_roll;
    pad_t [n_clusters-1:0]  exp_pad;
    feb_list_t              exp_list;
    inj_word_t              rd;
    logic                   err;
    int                     waits;
    int                     n;
    int                     e0;
    sm_reset      = 1'b1;
    link_clusters = '1;
    paddr         = '0;
    psel          = 1'b0;
    penable       = 1'b0;
    pwrite        = 1'b0;
    pwdata        = '0;
    inj_go        = 1'b0;
    inj_last_tbin = '0;

    for (int i = 0; i < n_sweep; i++) begin
      for (int j = 0; j < n_clusters; j++) stim[j] = {3'(i + j), 5'(4 * i + j), 6'(7 * i + 13 * j)};
      add_row($sformatf("vfat_sweep_%0d", i), stim);
    end
    for (int j = 0; j < n_clusters; j++) stim[j] = {3'(j), 2'b11, 9'(37 * j + 5)};
    add_row("all_invalid", stim);       // no board may light up
    for (int k = 0; k < n_random; k++) begin
      rnd = {$random(seed), $random(seed)};
      add_row($sformatf("random_%0d", k), rnd[55:0]);
    end

    repeat (2) @(posedge clock);
    sm_reset <= 1'b0;
    @(negedge clock);
    e0 = error_count;
    check_value("reset", "status", 64'(0), 64'({inj_busy, pready, pslverr, cluster_injected,
                                                cluster_vpf, active_feb_list}));
    test_done("reset", error_count - e0);

    // one row per cycle with decode checked 2 cycles later and board list 3 cycles later
    for (int c = 0; c < n_rows + 3; c++) begin
      @(posedge clock);
      if (c < n_rows) link_clusters <= stim_q[c];
      else            link_clusters <= '1;
      @(negedge clock);
      if (c >= 2 && c < n_rows + 2) begin
        e0 = error_count;
        check_outputs(name_q[c-2], stim_q[c-2], vpf_q[c-2], feb_q[c-2], roll_q[c-2],
                      pad_q[c-2], 1'b0);
        row_errs[c-2] = error_count - e0;
      end
      if (c >= 3) begin
        e0 = error_count;
        check_value(name_q[c-3], "feb list", 64'(list_q[c-3]), 64'(active_feb_list));
        test_done(name_q[c-3], row_errs[c-3] + error_count - e0);
      end
    end

    e0 = error_count;
    for (int j = 0; j < n_clusters; j++) begin
      for (int t = 0; t < 6; t++) begin
        inj_mem[j][t] = 16'($random(seed));
        apb_write({2'(j), 10'(t)}, inj_mem[j][t], err);
        check_value("apb_rw", "pslverr", 64'(0), 64'(err));
      end
    end
    for (int j = 0; j < n_clusters; j++) begin
      for (int t = 0; t < 6; t += 5) begin
        apb_read({2'(j), 10'(t)}, rd, waits);
        check_value("apb_rw", "read data", 64'(inj_mem[j][t]), 64'(rd));
        check_value("apb_rw", "wait states", 64'(1), 64'(waits));
      end
    end
    test_done("apb_rw", error_count - e0);

    e0 = error_count;
    n  = 0;
    start_playback(12'd5);
    do begin
      @(negedge clock);
      if (n > 0 && n <= 6) begin
        // board list trails the previous crossing by one cycle
        check_value("inj_playback", "feb list", 64'(exp_list), 64'(active_feb_list));
      end
      if (cluster_injected) begin
        if (n < 6) begin
          for (int j = 0; j < n_clusters; j++) stim[j] = inj_mem[j][n][cluster_bits-1:0];
          expect_row(stim, exp_vpf, exp_feb, exp_roll, exp_pad, exp_list);
          check_outputs("inj_playback", stim, exp_vpf, exp_feb, exp_roll, exp_pad, 1'b1);
        end
        n++;
      end
    end while (n == 0 || cluster_injected);  // a gap ends the count early
    check_value("inj_playback", "crossings", 64'(6), 64'(n));
    check_value("inj_playback", "inj_busy", 64'(0), 64'(inj_busy));
    test_done("inj_playback", error_count - e0);

    e0 = error_count;
    start_playback(12'd20);
    @(negedge clock);
    while (!inj_busy) @(negedge clock);
    apb_write({2'd2, 10'd3}, ~inj_mem[2][3], err);
    check_value("apb_busy_write", "pslverr", 64'(1), 64'(err));
    while (inj_busy) @(negedge clock);
    apb_read({2'd2, 10'd3}, rd, waits);
    check_value("apb_busy_write", "read data", 64'(inj_mem[2][3]), 64'(rd));
    test_done("apb_busy_write", error_count - e0);

    $display("tests %0d, tests failed %0d, check errors %0d", tests_run, tests_failed,
             error_count);
    if (error_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

//--- gem_cluster_top.f
gem_cluster_pkg.sv
gem_inj_pkg.sv
gem_decoded_if.sv
gem_inj_seq.sv
gem_inj_ram.sv
gem_cluster_select.sv
gem_cluster_decode.sv
gem_feb_occupancy.sv
gem_cluster_top.sv
gem_cluster_checker.sv
tb_gem_cluster_top.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_gem_cluster_top
FILELIST  = gem_cluster_top.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)

run: compile
	./$(OBJ_DIR)/$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Regression failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "Regression passed" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
